// ==== include/dccm_cfg.svh ====
`ifndef DCCM_CFG_SVH
`define DCCM_CFG_SVH

// dccm geometry
`define DCCM_BITS        16              // byte address width
`define DCCM_DATA_WIDTH  32              // one bank word
`define DCCM_BYTE_WIDTH  4               // bytes per bank word
`define DCCM_WIDTH_BITS  2               // byte offset within a word
`define DCCM_BANK_BITS   1               // bank index above the offset

// pic window
`define PIC_BITS         15              // offset bits kept in the pic address
`define PIC_BASE_ADDR    32'hF00C0000    // pic region base

// dma buffer
`define DMA_TAG_BITS     3               // dma buffer entry tag

// system side
`define SYS_ADDR_WIDTH   32              // core address width

`endif

// ==== verilog/dccm_pkg.sv ====
`include "dccm_cfg.svh"

package dccm_pkg;

   // dccm byte address
   typedef logic [`DCCM_BITS-1:0] dccm_addr_t;

   // one bank word and its byte enables
   typedef logic [`DCCM_DATA_WIDTH-1:0] bank_data_t;
   typedef logic [`DCCM_BYTE_WIDTH-1:0] byte_en_t;

   // lo/hi bank pair
   typedef logic [2*`DCCM_DATA_WIDTH-1:0] dword_t;
   typedef logic [2*`DCCM_BYTE_WIDTH-1:0] dword_en_t;

   // core address
   typedef logic [`SYS_ADDR_WIDTH-1:0] sys_addr_t;

   // dma buffer tag
   typedef logic [`DMA_TAG_BITS-1:0] dma_tag_t;

   // load/store access size
   typedef enum logic [1:0] {
      size_byte  = 2'b00,
      size_half  = 2'b01,
      size_word  = 2'b10,
      size_dword = 2'b11
   } access_size_e;

endpackage

// ==== verilog/dccm_req_decode.sv ====
`include "dccm_cfg.svh"

module dccm_req_decode
   import dccm_pkg::*;
(
   input  logic         lsu_valid_d,
   input  logic         lsu_load_d,
   input  access_size_e lsu_size_d,
   input  sys_addr_t    lsu_addr_d,
   input  logic         addr_in_dccm_d,
   input  logic         addr_in_pic_d,
   input  logic         dma_dccm_wen,
   input  bank_data_t   dma_wdata_lo,
   input  bank_data_t   dma_wdata_hi,
   input  logic         stbuf_reqvld_any,
   input  dccm_addr_t   stbuf_addr_any,
   input  bank_data_t   stbuf_data_any,
   output logic         dccm_rden,
   output dccm_addr_t   dccm_rd_addr_lo,
   output dccm_addr_t   dccm_rd_addr_hi,
   output logic         dccm_wren,
   output dccm_addr_t   dccm_wr_addr_lo,
   output dccm_addr_t   dccm_wr_addr_hi,
   output bank_data_t   dccm_wr_data_lo,
   output bank_data_t   dccm_wr_data_hi,
   output logic         lsu_stbuf_commit_any,
   output logic         picm_rden,
   output sys_addr_t    picm_rdaddr,
   output logic         ldst_dual_d
);

   logic [2:0]                 size_m1;     // access bytes minus one
   dccm_addr_t                 addr_d;
   dccm_addr_t                 end_addr_d;
   logic [`DCCM_BANK_BITS-1:0] stbuf_bank;
   logic [`DCCM_BANK_BITS-1:0] rd_bank_lo;
   logic [`DCCM_BANK_BITS-1:0] rd_bank_hi;
   logic                       bank_conflict;

   always_comb begin
      case (lsu_size_d)
         size_byte: size_m1 = 3'd0;
         size_half: size_m1 = 3'd1;
         size_word: size_m1 = 3'd3;
         default:   size_m1 = 3'd7;
      endcase
   end

   assign addr_d     = lsu_addr_d[`DCCM_BITS-1:0];
   assign end_addr_d = addr_d + dccm_addr_t'(size_m1);   // last byte touched

   // crossing into the next word needs the hi bank too
   assign ldst_dual_d = end_addr_d[`DCCM_BITS-1:`DCCM_WIDTH_BITS] !=
                        addr_d[`DCCM_BITS-1:`DCCM_WIDTH_BITS];

   assign dccm_rden       = lsu_valid_d & lsu_load_d & addr_in_dccm_d;
   assign dccm_rd_addr_lo = addr_d;
   assign dccm_rd_addr_hi = end_addr_d;

   // pic registers are words, base plus offset
   assign picm_rden   = lsu_valid_d & lsu_load_d & addr_in_pic_d;
   assign picm_rdaddr = `PIC_BASE_ADDR |
                        {{(`SYS_ADDR_WIDTH-`PIC_BITS){1'b0}}, lsu_addr_d[`PIC_BITS-1:0]};

   assign stbuf_bank = stbuf_addr_any[`DCCM_WIDTH_BITS +: `DCCM_BANK_BITS];
   assign rd_bank_lo = addr_d[`DCCM_WIDTH_BITS +: `DCCM_BANK_BITS];
   assign rd_bank_hi = end_addr_d[`DCCM_WIDTH_BITS +: `DCCM_BANK_BITS];

   // a read holds one or both banks this cycle
   assign bank_conflict = dccm_rden & ((stbuf_bank == rd_bank_lo) | (stbuf_bank == rd_bank_hi));

   // dma owns the write port outright
   assign lsu_stbuf_commit_any = stbuf_reqvld_any & ~dma_dccm_wen & ~bank_conflict;

   assign dccm_wren       = dma_dccm_wen | lsu_stbuf_commit_any;
   assign dccm_wr_addr_lo = dma_dccm_wen ? addr_d : stbuf_addr_any;
   assign dccm_wr_addr_hi = dma_dccm_wen ? end_addr_d : stbuf_addr_any;
   assign dccm_wr_data_lo = dma_dccm_wen ? dma_wdata_lo : stbuf_data_any;
   assign dccm_wr_data_hi = dma_dccm_wen ? dma_wdata_hi : stbuf_data_any;

endmodule

// ==== verilog/dccm_load_pipe.sv ====
`include "dccm_cfg.svh"

module dccm_load_pipe
   import dccm_pkg::*;
(
   input  logic                        clk,
   input  logic                        rst,
   input  logic                        lsu_valid_d,
   input  logic                        lsu_load_d,
   input  logic                        lsu_dma_d,
   input  logic [`DCCM_WIDTH_BITS-1:0] lsu_addr_d,
   input  logic                        addr_in_dccm_d,
   input  logic                        addr_in_pic_d,
   input  logic                        ldst_dual_d,
   input  dma_tag_t                    dma_tag_d,
   input  bank_data_t                  dccm_rd_data_lo,
   input  bank_data_t                  dccm_rd_data_hi,
   input  bank_data_t                  stbuf_fwddata_lo_m,
   input  bank_data_t                  stbuf_fwddata_hi_m,
   input  byte_en_t                    stbuf_fwdbyteen_lo_m,
   input  byte_en_t                    stbuf_fwdbyteen_hi_m,
   input  bank_data_t                  picm_rd_data,
   output logic                        ld_valid_r,
   output logic                        dma_r,
   output logic [`DCCM_WIDTH_BITS-1:0] offset_r,
   output logic                        in_dccm_r,
   output logic                        in_pic_r,
   output logic                        dual_r,
   output dma_tag_t                    dma_tag_r,
   output dword_t                      dccm_rdata_r,
   output dword_t                      fwddata_r,
   output dword_en_t                   fwdbyteen_r,
   output bank_data_t                  pic_data_r
);

   logic                        valid_m;
   logic                        dma_m;
   logic [`DCCM_WIDTH_BITS-1:0] offset_m;
   logic                        in_dccm_m;
   logic                        in_pic_m;
   logic                        dual_m;
   dma_tag_t                    dma_tag_m;
   bank_data_t                  rdata_lo_r;
   bank_data_t                  rdata_hi_r;
   logic                        rden_m;
   logic                        fwd_en_m;

   // load valid down the pipe
   always_ff @(posedge clk) begin
      if (rst) begin
         valid_m    <= 1'b0;
         ld_valid_r <= 1'b0;
      end else begin
         valid_m    <= lsu_valid_d & lsu_load_d;
         ld_valid_r <= valid_m;
      end
   end

   always_ff @(posedge clk) begin
      dma_m     <= lsu_dma_d;      // d -> m
      offset_m  <= lsu_addr_d;
      in_dccm_m <= addr_in_dccm_d;
      in_pic_m  <= addr_in_pic_d;
      dual_m    <= ldst_dual_d;
      dma_tag_m <= dma_tag_d;
      dma_r     <= dma_m;          // m -> r
      offset_r  <= offset_m;
      in_dccm_r <= in_dccm_m;
      in_pic_r  <= in_pic_m;
      dual_r    <= dual_m;
      dma_tag_r <= dma_tag_m;
      fwdbyteen_r <= {stbuf_fwdbyteen_hi_m, stbuf_fwdbyteen_lo_m};
   end

   assign rden_m   = valid_m & in_dccm_m;
   assign fwd_en_m = |{stbuf_fwdbyteen_hi_m, stbuf_fwdbyteen_lo_m};

   // returned data lands in r only when it is needed
   always_ff @(posedge clk) begin
      if (rden_m) begin
         rdata_lo_r <= dccm_rd_data_lo;
      end
      if (rden_m & dual_m) begin
         rdata_hi_r <= dccm_rd_data_hi;   // hi bank only on word crossing
      end
      if (valid_m & in_pic_m) begin
         pic_data_r <= picm_rd_data;
      end
      if (fwd_en_m) begin
         fwddata_r <= {stbuf_fwddata_hi_m, stbuf_fwddata_lo_m};
      end
   end

   assign dccm_rdata_r = {rdata_hi_r, rdata_lo_r};

endmodule

// ==== verilog/dccm_load_result.sv ====
`include "dccm_cfg.svh"

module dccm_load_result
   import dccm_pkg::*;
(
   input  logic                        ld_valid_r,
   input  logic                        dma_r,
   input  logic [`DCCM_WIDTH_BITS-1:0] offset_r,
   input  logic                        in_dccm_r,
   input  logic                        in_pic_r,
   input  logic                        dual_r,
   input  dma_tag_t                    dma_tag_r,
   input  dword_t                      dccm_rdata_r,
   input  dword_t                      fwddata_r,
   input  dword_en_t                   fwdbyteen_r,
   input  bank_data_t                  pic_data_r,
   output bank_data_t                  lsu_ld_data_r,
   output logic                        dccm_dma_rvalid,
   output dma_tag_t                    dccm_dma_rtag,
   output dword_t                      dccm_dma_rdata
);

   dword_t pic_dword;
   dword_t merged;
   dword_t shifted;

   assign pic_dword = {2{pic_data_r}};   // pic word seen in both halves

   // forward beats pic, pic beats dccm
   always_comb begin
      for (int i = 0; i < 2*`DCCM_BYTE_WIDTH; i++) begin
         if (fwdbyteen_r[i]) begin
            merged[8*i +: 8] = fwddata_r[8*i +: 8];
         end else if (in_pic_r) begin
            merged[8*i +: 8] = pic_dword[8*i +: 8];
         end else if (in_dccm_r) begin
            merged[8*i +: 8] = dccm_rdata_r[8*i +: 8];
         end else begin
            merged[8*i +: 8] = 8'h00;
         end
      end
   end

   // byte at the address goes to bit 0
   assign shifted       = merged >> {offset_r, 3'b000};
   assign lsu_ld_data_r = shifted[`DCCM_DATA_WIDTH-1:0];

   assign dccm_dma_rvalid = ld_valid_r & dma_r;
   assign dccm_dma_rtag   = dma_tag_r;

   // single word repeated when the access stayed in one bank
   assign dccm_dma_rdata = dual_r ? merged : {2{merged[`DCCM_DATA_WIDTH-1:0]}};

endmodule

// ==== verilog/dccm_ctl.sv ====
`include "dccm_cfg.svh"

module dccm_ctl
   import dccm_pkg::*;
(
   input  logic         clk,
   input  logic         rst,
   input  logic         lsu_valid_d,
   input  logic         lsu_load_d,
   input  logic         lsu_dma_d,
   input  access_size_e lsu_size_d,
   input  sys_addr_t    lsu_addr_d,
   input  logic         addr_in_dccm_d,
   input  logic         addr_in_pic_d,
   input  dma_tag_t     dma_tag_d,
   input  logic         dma_dccm_wen,
   input  bank_data_t   dma_wdata_lo,
   input  bank_data_t   dma_wdata_hi,
   input  logic         stbuf_reqvld_any,
   input  dccm_addr_t   stbuf_addr_any,
   input  bank_data_t   stbuf_data_any,
   input  bank_data_t   stbuf_fwddata_lo_m,
   input  bank_data_t   stbuf_fwddata_hi_m,
   input  byte_en_t     stbuf_fwdbyteen_lo_m,
   input  byte_en_t     stbuf_fwdbyteen_hi_m,
   input  bank_data_t   dccm_rd_data_lo,
   input  bank_data_t   dccm_rd_data_hi,
   input  bank_data_t   picm_rd_data,
   output logic         dccm_rden,
   output logic         dccm_wren,
   output dccm_addr_t   dccm_rd_addr_lo,
   output dccm_addr_t   dccm_rd_addr_hi,
   output dccm_addr_t   dccm_wr_addr_lo,
   output dccm_addr_t   dccm_wr_addr_hi,
   output bank_data_t   dccm_wr_data_lo,
   output bank_data_t   dccm_wr_data_hi,
   output logic         picm_rden,
   output sys_addr_t    picm_rdaddr,
   output logic         lsu_stbuf_commit_any,
   output logic         ld_valid_r,
   output bank_data_t   lsu_ld_data_r,
   output logic         dccm_dma_rvalid,
   output dma_tag_t     dccm_dma_rtag,
   output dword_t       dccm_dma_rdata
);

   logic                        ldst_dual_d;
   logic                        dma_r;
   logic [`DCCM_WIDTH_BITS-1:0] offset_r;
   logic                        in_dccm_r;
   logic                        in_pic_r;
   logic                        dual_r;
   dma_tag_t                    dma_tag_r;
   dword_t                      dccm_rdata_r;
   dword_t                      fwddata_r;
   dword_en_t                   fwdbyteen_r;
   bank_data_t                  pic_data_r;

   // d stage: read/write port control
   dccm_req_decode u_decode (
      .lsu_valid_d          (lsu_valid_d),
      .lsu_load_d           (lsu_load_d),
      .lsu_size_d           (lsu_size_d),
      .lsu_addr_d           (lsu_addr_d),
      .addr_in_dccm_d       (addr_in_dccm_d),
      .addr_in_pic_d        (addr_in_pic_d),
      .dma_dccm_wen         (dma_dccm_wen),
      .dma_wdata_lo         (dma_wdata_lo),
      .dma_wdata_hi         (dma_wdata_hi),
      .stbuf_reqvld_any     (stbuf_reqvld_any),
      .stbuf_addr_any       (stbuf_addr_any),
      .stbuf_data_any       (stbuf_data_any),
      .dccm_rden            (dccm_rden),
      .dccm_rd_addr_lo      (dccm_rd_addr_lo),
      .dccm_rd_addr_hi      (dccm_rd_addr_hi),
      .dccm_wren            (dccm_wren),
      .dccm_wr_addr_lo      (dccm_wr_addr_lo),
      .dccm_wr_addr_hi      (dccm_wr_addr_hi),
      .dccm_wr_data_lo      (dccm_wr_data_lo),
      .dccm_wr_data_hi      (dccm_wr_data_hi),
      .lsu_stbuf_commit_any (lsu_stbuf_commit_any),
      .picm_rden            (picm_rden),
      .picm_rdaddr          (picm_rdaddr),
      .ldst_dual_d          (ldst_dual_d)
   );

   // d -> m -> r registers
   dccm_load_pipe u_pipe (
      .clk                  (clk),
      .rst                  (rst),
      .lsu_valid_d          (lsu_valid_d),
      .lsu_load_d           (lsu_load_d),
      .lsu_dma_d            (lsu_dma_d),
      .lsu_addr_d           (lsu_addr_d[`DCCM_WIDTH_BITS-1:0]),
      .addr_in_dccm_d       (addr_in_dccm_d),
      .addr_in_pic_d        (addr_in_pic_d),
      .ldst_dual_d          (ldst_dual_d),
      .dma_tag_d            (dma_tag_d),
      .dccm_rd_data_lo      (dccm_rd_data_lo),
      .dccm_rd_data_hi      (dccm_rd_data_hi),
      .stbuf_fwddata_lo_m   (stbuf_fwddata_lo_m),
      .stbuf_fwddata_hi_m   (stbuf_fwddata_hi_m),
      .stbuf_fwdbyteen_lo_m (stbuf_fwdbyteen_lo_m),
      .stbuf_fwdbyteen_hi_m (stbuf_fwdbyteen_hi_m),
      .picm_rd_data         (picm_rd_data),
      .ld_valid_r           (ld_valid_r),
      .dma_r                (dma_r),
      .offset_r             (offset_r),
      .in_dccm_r            (in_dccm_r),
      .in_pic_r             (in_pic_r),
      .dual_r               (dual_r),
      .dma_tag_r            (dma_tag_r),
      .dccm_rdata_r         (dccm_rdata_r),
      .fwddata_r            (fwddata_r),
      .fwdbyteen_r          (fwdbyteen_r),
      .pic_data_r           (pic_data_r)
   );

   // r stage: merge and return
   dccm_load_result u_result (
      .ld_valid_r           (ld_valid_r),
      .dma_r                (dma_r),
      .offset_r             (offset_r),
      .in_dccm_r            (in_dccm_r),
      .in_pic_r             (in_pic_r),
      .dual_r               (dual_r),
      .dma_tag_r            (dma_tag_r),
      .dccm_rdata_r         (dccm_rdata_r),
      .fwddata_r            (fwddata_r),
      .fwdbyteen_r          (fwdbyteen_r),
      .pic_data_r           (pic_data_r),
      .lsu_ld_data_r        (lsu_ld_data_r),
      .dccm_dma_rvalid      (dccm_dma_rvalid),
      .dccm_dma_rtag        (dccm_dma_rtag),
      .dccm_dma_rdata       (dccm_dma_rdata)
   );

endmodule

// ==== sim/dccm_ctl_chk.sv ====
module dccm_ctl_chk
   import dccm_pkg::*;
(
   input logic         clk,
   input logic         rst,
   input logic         lsu_valid_d, lsu_load_d, lsu_dma_d, addr_in_dccm_d, addr_in_pic_d,
   input access_size_e lsu_size_d,
   input sys_addr_t    lsu_addr_d, picm_rdaddr,
   input dma_tag_t     dma_tag_d, dccm_dma_rtag,
   input logic         dma_dccm_wen, stbuf_reqvld_any, dccm_rden, dccm_wren, picm_rden,
   input logic         lsu_stbuf_commit_any, ld_valid_r, dccm_dma_rvalid,
   input bank_data_t   dma_wdata_lo, dma_wdata_hi, stbuf_data_any, lsu_ld_data_r,
   input bank_data_t   dccm_wr_data_lo, dccm_wr_data_hi,
   input dccm_addr_t   stbuf_addr_any, dccm_rd_addr_lo, dccm_rd_addr_hi,
   input dccm_addr_t   dccm_wr_addr_lo, dccm_wr_addr_hi,
   input byte_en_t     stbuf_fwdbyteen_lo_m, stbuf_fwdbyteen_hi_m,
   input dword_t       dccm_dma_rdata
);

   localparam sys_addr_t  pic_base = 32'hF00C0000;
   localparam bank_data_t pic_xor  = 32'h5A5A5A5A;

   int fail_count = 0;

   sys_addr_t    addr_m, addr_r;                  // request shadow, m then r
   access_size_e size_m, size_r;
   dma_tag_t     tag_m, tag_r;
   logic [1:0]   vld_q, dma_q, pic_q, dccm_q;     // bit 0 in m, bit 1 in r
   dword_en_t    fwd_r;
   dccm_addr_t   end_d, end_r;
   logic         rd_d, commit_exp, dual_exp;
   dword_t       merged_exp, dma_exp;
   bank_data_t   ld_exp, ld_mask;
   logic [95:0]  wr_exp;

   function automatic int nbytes(access_size_e s);
      return 1 << s;
   endfunction

   // expected lo/hi pair, forward over pic over memory
   function automatic dword_t pair_exp(sys_addr_t a, logic pic, logic dccm, dword_en_t fwd);
      dword_t     d;
      bank_data_t pw;
      dccm_addr_t b;
      pw = (pic_base | (a & 32'h7FFF)) ^ pic_xor;
      for (int i = 0; i < 8; i++) begin
         b = {a[15:2], 2'b00} + dccm_addr_t'(i);
         if (fwd[i])
            d[8*i +: 8] = 8'hF0 + 8'(i);
         else if (pic)
            d[8*i +: 8] = pw[8*(i%4) +: 8];
         else if (dccm)
            d[8*i +: 8] = b[7:0] ^ 8'hA5;
         else
            d[8*i +: 8] = 8'h00;
      end
      return d;
   endfunction

   task automatic flag(string msg);
      $error("%s", msg);
      fail_count++;
   endtask

   always @(posedge clk) begin
      vld_q  <= rst ? 2'b00 : {vld_q[0], lsu_valid_d & lsu_load_d};
      dma_q  <= {dma_q[0], lsu_dma_d};
      pic_q  <= {pic_q[0], addr_in_pic_d};
      dccm_q <= {dccm_q[0], addr_in_dccm_d};
      addr_m <= lsu_addr_d;
      addr_r <= addr_m;
      size_m <= lsu_size_d;
      size_r <= size_m;
      tag_m  <= dma_tag_d;
      tag_r  <= tag_m;
      fwd_r  <= {stbuf_fwdbyteen_hi_m, stbuf_fwdbyteen_lo_m};   // m stage enables
   end

   assign rd_d  = lsu_valid_d & lsu_load_d & addr_in_dccm_d;
   assign end_d = lsu_addr_d[15:0] + dccm_addr_t'(nbytes(lsu_size_d) - 1);
   assign end_r = addr_r[15:0] + dccm_addr_t'(nbytes(size_r) - 1);

   // store buffer yields to dma and to a read on its bank
   assign commit_exp = stbuf_reqvld_any & ~dma_dccm_wen & (~rd_d |
                       (stbuf_addr_any[2] != lsu_addr_d[2] && stbuf_addr_any[2] != end_d[2]));
   assign wr_exp = dma_dccm_wen ? {lsu_addr_d[15:0], end_d, dma_wdata_lo, dma_wdata_hi} :
                   {stbuf_addr_any, stbuf_addr_any, stbuf_data_any, stbuf_data_any};

   assign merged_exp = pair_exp(addr_r, pic_q[1], dccm_q[1], fwd_r);
   assign ld_exp     = bank_data_t'(merged_exp >> (8 * addr_r[1:0]));
   assign ld_mask    = bank_data_t'((64'd1 << (8 * nbytes(size_r))) - 64'd1);
   assign dual_exp   = end_r[15:2] != addr_r[15:2];
   assign dma_exp    = dual_exp ? merged_exp : {2{merged_exp[31:0]}};

   a_valids: assert property (@(posedge clk) disable iff (rst)
      {ld_valid_r, dccm_dma_rvalid} == {vld_q[1], vld_q[1] & dma_q[1]})
      else flag($sformatf("** Error ld_valid_r/dccm_dma_rvalid exp %h got %h",
                          $sampled({vld_q[1], vld_q[1] & dma_q[1]}),
                          $sampled({ld_valid_r, dccm_dma_rvalid})));

   a_ld_data: assert property (@(posedge clk) disable iff (rst)
      ld_valid_r |-> ((lsu_ld_data_r ^ ld_exp) & ld_mask) == '0)
      else flag($sformatf("** Error lsu_ld_data_r exp %h got %h mask %h",
                          $sampled(ld_exp), $sampled(lsu_ld_data_r), $sampled(ld_mask)));

   a_dma_ret: assert property (@(posedge clk) disable iff (rst)
      dccm_dma_rvalid |-> dccm_dma_rtag == tag_r && dccm_dma_rdata == dma_exp)
      else flag($sformatf("** Error dccm_dma_rtag/rdata exp %h %h got %h %h",
                          $sampled(tag_r), $sampled(dma_exp),
                          $sampled(dccm_dma_rtag), $sampled(dccm_dma_rdata)));

   a_rden: assert property (@(posedge clk) disable iff (rst)
      {dccm_rden, picm_rden} == {rd_d, lsu_valid_d & lsu_load_d & addr_in_pic_d})
      else flag($sformatf("** Error dccm_rden/picm_rden exp %h got %h",
                          $sampled({rd_d, lsu_valid_d & lsu_load_d & addr_in_pic_d}),
                          $sampled({dccm_rden, picm_rden})));

   a_rd_addr: assert property (@(posedge clk) disable iff (rst)
      dccm_rden |-> dccm_rd_addr_lo == lsu_addr_d[15:0] && dccm_rd_addr_hi == end_d)
      else flag($sformatf("** Error dccm_rd_addr_lo/hi exp %h %h got %h %h",
                          $sampled(lsu_addr_d[15:0]), $sampled(end_d),
                          $sampled(dccm_rd_addr_lo), $sampled(dccm_rd_addr_hi)));

   a_pic_addr: assert property (@(posedge clk) disable iff (rst)
      picm_rden |-> picm_rdaddr == (pic_base | (lsu_addr_d & 32'h7FFF)))
      else flag($sformatf("** Error picm_rdaddr exp %h got %h",
                          $sampled(pic_base | (lsu_addr_d & 32'h7FFF)),
                          $sampled(picm_rdaddr)));

   a_commit: assert property (@(posedge clk) disable iff (rst)
      {lsu_stbuf_commit_any, dccm_wren} == {commit_exp, dma_dccm_wen | commit_exp})
      else flag($sformatf("** Error lsu_stbuf_commit_any/dccm_wren exp %h got %h",
                          $sampled({commit_exp, dma_dccm_wen | commit_exp}),
                          $sampled({lsu_stbuf_commit_any, dccm_wren})));

   a_wr_port: assert property (@(posedge clk) disable iff (rst)
      dccm_wren |-> {dccm_wr_addr_lo, dccm_wr_addr_hi, dccm_wr_data_lo, dccm_wr_data_hi} == wr_exp)
      else flag($sformatf("** Error dccm_wr_addr_lo/hi, dccm_wr_data_lo/hi exp %h got %h",
                          $sampled(wr_exp), $sampled({dccm_wr_addr_lo, dccm_wr_addr_hi,
                                                      dccm_wr_data_lo, dccm_wr_data_hi})));

endmodule

// ==== sim/dccm_ctl_tb.sv ====
module dccm_ctl_tb
   import dccm_pkg::*;
();

   logic         clk = 1'b0;
   logic         rst;
   logic         lsu_valid_d, lsu_load_d, lsu_dma_d, addr_in_dccm_d, addr_in_pic_d;
   access_size_e lsu_size_d;
   sys_addr_t    lsu_addr_d, picm_rdaddr;
   dma_tag_t     dma_tag_d, dccm_dma_rtag;
   logic         dma_dccm_wen, stbuf_reqvld_any;
   bank_data_t   dma_wdata_lo, dma_wdata_hi, stbuf_data_any;
   dccm_addr_t   stbuf_addr_any;
   bank_data_t   stbuf_fwddata_lo_m, stbuf_fwddata_hi_m;
   byte_en_t     stbuf_fwdbyteen_lo_m, stbuf_fwdbyteen_hi_m;
   bank_data_t   dccm_rd_data_lo, dccm_rd_data_hi, picm_rd_data;
   logic         dccm_rden, dccm_wren, picm_rden, lsu_stbuf_commit_any;
   logic         ld_valid_r, dccm_dma_rvalid;
   dccm_addr_t   dccm_rd_addr_lo, dccm_rd_addr_hi, dccm_wr_addr_lo, dccm_wr_addr_hi;
   bank_data_t   dccm_wr_data_lo, dccm_wr_data_hi, lsu_ld_data_r;
   dword_t       dccm_dma_rdata;

   logic [15:0]  lfsr = 16'd38;
   dword_en_t    fwd_pending;                   // enables for the load now in d
   dma_tag_t     tag_next;
   int           tests, tests_ok, timeouts, errs_at_start;

   dccm_ctl UUT (.*);

   bind dccm_ctl dccm_ctl_chk u_chk (.*);

   always #4 clk = ~clk;

   // aligned word, each byte is its address xor a5
   function automatic bank_data_t mem_word(dccm_addr_t a);
      bank_data_t w;
      for (int i = 0; i < 4; i++)
         w[8*i +: 8] = ((a[7:0] & 8'hFC) + 8'(i)) ^ 8'hA5;
      return w;
   endfunction

   always @(posedge clk) begin
      if (dccm_rden) begin
         dccm_rd_data_lo <= mem_word(dccm_rd_addr_lo);
         dccm_rd_data_hi <= mem_word(dccm_rd_addr_hi);
      end
      if (picm_rden)
         picm_rd_data <= picm_rdaddr ^ 32'h5A5A5A5A;   // pic answers the next cycle
   end

   // taps 16 14 13 11, one step per bit
   function automatic logic [7:0] rand_bits(int n);
      logic [7:0] r;
      r = 8'h00;
      for (int i = 0; i < n; i++) begin
         lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
         r    = {r[6:0], lfsr[0]};
      end
      return r;
   endfunction

   task automatic drive_load(sys_addr_t addr, access_size_e size, logic pic, logic dma,
                             dword_en_t fwd);
      lsu_valid_d    <= 1'b1;
      lsu_load_d     <= 1'b1;
      lsu_dma_d      <= dma;
      lsu_size_d     <= size;
      lsu_addr_d     <= addr;
      addr_in_pic_d  <= pic;
      addr_in_dccm_d <= ~pic;
      dma_tag_d      <= tag_next;
      tag_next++;
      {stbuf_fwdbyteen_hi_m, stbuf_fwdbyteen_lo_m} <= fwd_pending;   // previous load is in m
      fwd_pending = fwd;
   endtask

   task automatic issue_load(sys_addr_t addr, access_size_e size, logic pic, logic dma,
                             dword_en_t fwd);
      @(posedge clk);
      drive_load(addr, size, pic, dma, fwd);
   endtask

   task automatic idle();
      @(posedge clk);
      lsu_valid_d  <= 1'b0;
      lsu_load_d   <= 1'b0;
      lsu_dma_d    <= 1'b0;
      dma_dccm_wen <= 1'b0;
      {stbuf_fwdbyteen_hi_m, stbuf_fwdbyteen_lo_m} <= fwd_pending;
      fwd_pending = '0;
   endtask

   // returns start, then the pipe empties
   task automatic drain();
      int n;
      n = 0;
      do begin
         @(negedge clk);
         n++;
      end while (!ld_valid_r && n < 8);
      if (!ld_valid_r) begin
         $display("timeout: no load return within 8 cycles");
         timeouts++;
      end
      n = 0;
      while (ld_valid_r && n < 32) begin
         @(negedge clk);
         n++;
      end
      if (ld_valid_r) begin
         $display("timeout: load returns did not stop within 32 cycles");
         timeouts++;
      end
   endtask

   task automatic wait_commit();
      int n;
      n = 0;
      do begin
         @(negedge clk);
         n++;
      end while (!lsu_stbuf_commit_any && n < 8);
      if (!lsu_stbuf_commit_any) begin
         $display("timeout: store buffer did not commit within 8 cycles");
         timeouts++;
      end
   endtask

   task automatic end_test(string name);
      int errs;
      errs = UUT.u_chk.fail_count + timeouts;
      tests++;
      if (errs == errs_at_start) begin
         tests_ok++;
         $display("test %0d %s: ok", tests, name);
      end else begin
         $display("test %0d %s: %0d failures", tests, name, errs - errs_at_start);
      end
      errs_at_start = errs;
   endtask

   initial begin
      logic [7:0] off;
      logic [7:0] sz;
      logic [7:0] en;
      rst = 1'b1;
      lsu_valid_d = 1'b0;
      lsu_load_d = 1'b0;
      lsu_dma_d = 1'b0;
      addr_in_dccm_d = 1'b0;
      addr_in_pic_d = 1'b0;
      lsu_size_d = size_byte;
      lsu_addr_d = '0;
      dma_tag_d = '0;
      dma_dccm_wen = 1'b0;
      dma_wdata_lo = '0;
      dma_wdata_hi = '0;
      stbuf_reqvld_any = 1'b0;
      stbuf_addr_any = '0;
      stbuf_data_any = '0;
      stbuf_fwddata_lo_m = 32'hF3F2F1F0;          // byte index plus f0
      stbuf_fwddata_hi_m = 32'hF7F6F5F4;
      stbuf_fwdbyteen_lo_m = '0;
      stbuf_fwdbyteen_hi_m = '0;
      dccm_rd_data_lo = '0;
      dccm_rd_data_hi = '0;
      picm_rd_data = '0;
      fwd_pending = '0;
      tag_next = '0;
      tests = 0;
      tests_ok = 0;
      timeouts = 0;
      errs_at_start = 0;
      repeat (3) @(posedge clk);
      rst <= 1'b0;

      issue_load(32'h0100, size_word, 1'b0, 1'b0, '0);
      issue_load(32'h0104, size_word, 1'b0, 1'b0, '0);
      idle();
      drain();
      end_test("aligned word loads");

      for (int i = 0; i < 12; i++) begin
         off = rand_bits(2);
         sz  = rand_bits(2);
         issue_load(32'h0200 + 8*i + off, access_size_e'(2'(sz % 3)), 1'b0, 1'b0, '0);
      end
      issue_load(32'h02FE, size_word, 1'b0, 1'b0, '0);   // crosses into the hi bank
      idle();
      drain();
      end_test("sized loads at random offsets");

      for (int i = 0; i < 8; i++) begin
         off = rand_bits(2);
         en  = rand_bits(8);
         issue_load(32'h0300 + 8*i + off, size_word, 1'b0, 1'b0, en);
      end
      idle();
      drain();
      end_test("store buffer forwarding");

      for (int i = 0; i < 4; i++) begin
         off = rand_bits(8);
         issue_load(32'hF00C0000 | {off, 2'b00}, size_word, 1'b1, 1'b0, '0);
      end
      issue_load(32'hF00C0123, size_byte, 1'b1, 1'b0, '0);
      idle();
      drain();
      end_test("pic loads");

      issue_load(32'h0400, size_word, 1'b0, 1'b1, '0);
      issue_load(32'h0405, size_word, 1'b0, 1'b1, '0);   // dual
      issue_load(32'h0408, size_dword, 1'b0, 1'b1, '0);
      idle();
      drain();
      end_test("dma reads");

      @(posedge clk);
      dma_dccm_wen     <= 1'b1;                   // dma holds the write port
      lsu_addr_d       <= 32'h0412;
      lsu_size_d       <= size_word;
      dma_wdata_lo     <= 32'h12345678;
      dma_wdata_hi     <= 32'h9ABCDEF0;
      stbuf_reqvld_any <= 1'b1;
      stbuf_addr_any   <= 16'h0500;
      stbuf_data_any   <= 32'hCAFE0001;
      idle();
      wait_commit();                              // no read, no dma
      @(posedge clk);
      stbuf_addr_any <= 16'h0504;                 // bank 1 against a bank 0 read
      stbuf_data_any <= 32'hCAFE0002;
      drive_load(32'h0600, size_word, 1'b0, 1'b0, '0);
      wait_commit();
      @(posedge clk);
      stbuf_addr_any <= 16'h0508;                 // same bank as the read
      stbuf_data_any <= 32'hCAFE0003;
      drive_load(32'h0610, size_word, 1'b0, 1'b0, '0);
      idle();
      wait_commit();
      @(posedge clk);
      stbuf_reqvld_any <= 1'b0;
      drain();
      end_test("write port arbitration");

      $display("%0d of %0d tests ok, %0d assertion failures, %0d timeouts",
               tests_ok, tests, UUT.u_chk.fail_count, timeouts);
      if (UUT.u_chk.fail_count == 0 && timeouts == 0)
         $display("all tests passed");
      else
         $display("tests failed");
      $finish;
   end

endmodule

// ==== list.f ====
+incdir+include
verilog/dccm_pkg.sv
verilog/dccm_req_decode.sv
verilog/dccm_load_pipe.sv
verilog/dccm_load_result.sv
verilog/dccm_ctl.sv
sim/dccm_ctl_chk.sv
sim/dccm_ctl_tb.sv

// ==== Bender.yml ====
package:
  name: dccm_ctl

export_include_dirs:
  - include

sources:
  - verilog/dccm_pkg.sv
  - verilog/dccm_req_decode.sv
  - verilog/dccm_load_pipe.sv
  - verilog/dccm_load_result.sv
  - verilog/dccm_ctl.sv
  - target: simulation
    files:
      - sim/dccm_ctl_chk.sv
      - sim/dccm_ctl_tb.sv
